//--- common/backend_pkg.sv
package backend_pkg;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int ARCH_W    = 5;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    typedef logic [5:0] phys_tag_t;
    typedef logic [3:0] rob_id_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // R-type view
    typedef struct packed {
        logic [6:0]        funct7;
        logic [ARCH_W-1:0] rs2;
        logic [ARCH_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [ARCH_W-1:0] rd;
        logic [6:0]        opcode;
    } r_fields_t;

    // I-type view
    typedef struct packed {
        logic [11:0]       imm12;
        logic [ARCH_W-1:0] rs1;
        logic [2:0]        funct3;
        logic [ARCH_W-1:0] rd;
        logic [6:0]        opcode;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef struct packed {
        alu_op_e         op;
        phys_tag_t       rs1_tag;
        phys_tag_t       rs2_tag;
        logic            use_imm;
        logic [XLEN-1:0] imm;
        phys_tag_t       dst_tag;
        logic            dst_valid;  // rd is not x0
        rob_id_t         rob_id;
    } uop_t;

    typedef struct packed {
        logic [ARCH_W-1:0] rd_arch;
        phys_tag_t         tag;
        logic              dest_valid;
    } rob_alloc_t;

    typedef struct packed {
        logic            valid;
        phys_tag_t       tag;
        logic            dest_valid;
        rob_id_t         rob_id;
        logic [XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic [ARCH_W-1:0] rd_arch;
        phys_tag_t         tag;
        logic              dest_valid;
        logic [XLEN-1:0]   value;
    } commit_t;

endpackage

//--- rename/rat.sv
`timescale 1ns/10ps

module rat (
    input  logic                           clk,
    input  logic                           rst_n_i,

    input  logic [backend_pkg::ARCH_W-1:0] rs1_i,
    input  logic [backend_pkg::ARCH_W-1:0] rs2_i,
    output backend_pkg::phys_tag_t         rs1_tag_o,
    output backend_pkg::phys_tag_t         rs2_tag_o,

    input  logic                           we_i,
    input  logic [backend_pkg::ARCH_W-1:0] rd_i,
    input  backend_pkg::phys_tag_t         rd_tag_i
);
    import backend_pkg::*;

    phys_tag_t map_q [ARCH_REGS];

    // Entry 0 stays at tag 0, so x0 always reads as zero
    assign rs1_tag_o = map_q[rs1_i];
    assign rs2_tag_o = map_q[rs2_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (we_i && (rd_i != '0)) begin
            map_q[rd_i] <= rd_tag_i;
        end
    end

endmodule

//--- rename/free_list.sv
`timescale 1ns/10ps

module free_list #(
    parameter int PHYS_REGS = 48
) (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  logic                   pop_i,
    output backend_pkg::phys_tag_t tag_o,
    output logic                   ready_o,

    input  logic                   push_i,
    input  backend_pkg::phys_tag_t push_tag_i
);
    import backend_pkg::*;

    localparam int DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    phys_tag_t        tags_q [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;

    function automatic logic [PTR_W-1:0] bump(logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign tag_o   = tags_q[head_q];  // Next free tag shows before the pop
    assign ready_o = (count_q != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (PTR_W+1)'(DEPTH);
            // Starts full with every tag above the architectural ones
            for (int i = 0; i < DEPTH; i++) begin
                tags_q[i] <= phys_tag_t'(ARCH_REGS + i);
            end
        end else begin
            if (pop_i) begin
                head_q <= bump(head_q);
            end
            if (push_i) begin
                tags_q[tail_q] <= push_tag_i;
                tail_q         <= bump(tail_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- rename/rrf.sv
`timescale 1ns/10ps

module rrf (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  logic                   commit_valid_i,
    input  backend_pkg::commit_t   commit_i,

    output logic                   free_o,
    output backend_pkg::phys_tag_t free_tag_o
);
    import backend_pkg::*;

    phys_tag_t map_q [ARCH_REGS];

    // Old mapping of rd goes back to the free list as the new one retires
    assign free_o     = commit_valid_i && commit_i.dest_valid;
    assign free_tag_o = map_q[commit_i.rd_arch];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (free_o) begin
            map_q[commit_i.rd_arch] <= commit_i.tag;
        end
    end

endmodule

//--- rob/rob.sv
`timescale 1ns/10ps

module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n_i,

    input  logic                    alloc_i,
    input  backend_pkg::rob_alloc_t alloc_data_i,
    output backend_pkg::rob_id_t    tail_id_o,
    output logic                    ready_o,

    input  backend_pkg::cdb_t       cdb_i,

    output logic                    commit_valid_o,
    output backend_pkg::commit_t    commit_o
);
    import backend_pkg::*;

    localparam int IDW = $clog2(ROB_DEPTH);

    rob_alloc_t          info_q  [ROB_DEPTH];
    logic [XLEN-1:0]     value_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    logic [IDW-1:0]      head_q;
    logic [IDW-1:0]      tail_q;
    logic [IDW:0]        count_q;

    assign tail_id_o = rob_id_t'(tail_q);
    assign ready_o   = (count_q != (IDW+1)'(ROB_DEPTH));

    // ############################################################
    // Commit straight from the head entry
    assign commit_valid_o      = done_q[head_q];  // Done bits are cleared on retire
    assign commit_o.rd_arch    = info_q[head_q].rd_arch;
    assign commit_o.tag        = info_q[head_q].tag;
    assign commit_o.dest_valid = info_q[head_q].dest_valid;
    assign commit_o.value      = info_q[head_q].dest_valid ? value_q[head_q] : '0;

    // ############################################################
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (commit_valid_o) begin
                done_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            if (cdb_i.valid) begin
                done_q[cdb_i.rob_id[IDW-1:0]] <= 1'b1;
            end
            if (alloc_i) begin
                tail_q <= tail_q + 1'b1;
            end
            case ({alloc_i, commit_valid_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            info_q[tail_q] <= alloc_data_i;
        end
        if (cdb_i.valid) begin
            value_q[cdb_i.rob_id[IDW-1:0]] <= cdb_i.value;
        end
    end

endmodule

//--- logic/id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic                           instr_valid_i,
    input  backend_pkg::instr_u            instr_i,
    output logic                           instr_ready_o,

    input  logic                           rob_ready_i,
    input  logic                           fl_ready_i,
    input  logic                           rs_ready_i,

    output logic [backend_pkg::ARCH_W-1:0] rs1_o,
    output logic [backend_pkg::ARCH_W-1:0] rs2_o,
    input  backend_pkg::phys_tag_t         rs1_tag_i,
    input  backend_pkg::phys_tag_t         rs2_tag_i,
    input  backend_pkg::phys_tag_t         new_tag_i,
    input  backend_pkg::rob_id_t           rob_id_i,

    output logic                           rat_we_o,
    output logic                           fl_pop_o,
    output logic                           rob_alloc_o,
    output backend_pkg::rob_alloc_t        alloc_data_o,
    output logic                           rs_insert_o,
    output backend_pkg::uop_t              uop_o
);
    import backend_pkg::*;

    logic    is_imm;
    logic    need_dest;
    logic    accept;
    alu_op_e op;

    assign is_imm    = (instr_i.i_fields.opcode == OPC_OP_IMM);
    assign need_dest = (instr_i.r_fields.rd != '0);

    always_comb begin
        op = ALU_ADD;  // ADDI
        if (!is_imm) begin
            case (instr_i.r_fields.funct3)
                3'b000:  op = instr_i.r_fields.funct7[5] ? ALU_SUB : ALU_ADD;
                3'b100:  op = ALU_XOR;
                3'b110:  op = ALU_OR;
                3'b111:  op = ALU_AND;
                default: op = ALU_ADD;
            endcase
        end
    end

    // ############################################################
    // Rename and dispatch of one instruction per cycle
    assign instr_ready_o = rob_ready_i && rs_ready_i && (fl_ready_i || !need_dest);
    assign accept        = instr_valid_i && instr_ready_o;

    assign rs1_o = instr_i.r_fields.rs1;
    assign rs2_o = instr_i.r_fields.rs2;

    assign rat_we_o    = accept && need_dest;
    assign fl_pop_o    = accept && need_dest;
    assign rob_alloc_o = accept;
    assign rs_insert_o = accept;

    assign alloc_data_o.rd_arch    = instr_i.r_fields.rd;
    assign alloc_data_o.tag        = need_dest ? new_tag_i : '0;
    assign alloc_data_o.dest_valid = need_dest;

    assign uop_o.op        = op;
    assign uop_o.rs1_tag   = rs1_tag_i;
    assign uop_o.rs2_tag   = is_imm ? '0 : rs2_tag_i;  // Tag 0 is always ready
    assign uop_o.use_imm   = is_imm;
    assign uop_o.imm       = {{(XLEN-12){instr_i.i_fields.imm12[11]}}, instr_i.i_fields.imm12};
    assign uop_o.dst_tag   = alloc_data_o.tag;
    assign uop_o.dst_valid = need_dest;
    assign uop_o.rob_id    = rob_id_i;

endmodule

//--- logic/int_rs.sv
`timescale 1ns/10ps

module int_rs #(
    parameter int RS_DEPTH  = 4,
    parameter int PHYS_REGS = 48
) (
    input  logic                          clk,
    input  logic                          rst_n_i,

    input  logic                          insert_i,
    input  backend_pkg::uop_t             uop_i,
    output logic                          ready_o,

    input  backend_pkg::cdb_t             cdb_i,

    output backend_pkg::phys_tag_t        rd_tag_a_o,
    output backend_pkg::phys_tag_t        rd_tag_b_o,
    input  logic [backend_pkg::XLEN-1:0]  rd_val_a_i,
    input  logic [backend_pkg::XLEN-1:0]  rd_val_b_i,
    input  logic                          rd_rdy_a_i,
    input  logic                          rd_rdy_b_i,

    output backend_pkg::cdb_t             cdb_o
);
    import backend_pkg::*;

    localparam int IDX_W = $clog2(RS_DEPTH);
    localparam int TAG_W = $clog2(PHYS_REGS);

    uop_t                slot_q [RS_DEPTH];
    logic [IDX_W-1:0]    age_q  [RS_DEPTH];  // 0 is the youngest
    logic [RS_DEPTH-1:0] valid_q;
    logic [RS_DEPTH-1:0] rdy_a_q;
    logic [RS_DEPTH-1:0] rdy_b_q;

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] pick_idx;
    logic [IDX_W-1:0] best_age;
    logic             has_free;
    logic             has_pick;
    logic             issue;
    uop_t             pick;
    logic [XLEN-1:0]  op_b;
    logic [XLEN-1:0]  result;

    function automatic logic wake(phys_tag_t t, cdb_t c);
        return c.valid && c.dest_valid && (c.tag[TAG_W-1:0] == t[TAG_W-1:0]);
    endfunction

    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        has_pick = 1'b0;
        pick_idx = '0;
        best_age = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                has_free = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid_q[i] && rdy_a_q[i] && rdy_b_q[i] && (!has_pick || age_q[i] > best_age)) begin
                has_pick = 1'b1;
                pick_idx = IDX_W'(i);
                best_age = age_q[i];
            end
        end
    end

    assign ready_o = has_free;
    assign issue   = has_pick && !insert_i;  // Read ports serve the insert first
    assign pick    = slot_q[pick_idx];

    assign rd_tag_a_o = insert_i ? uop_i.rs1_tag : pick.rs1_tag;
    assign rd_tag_b_o = insert_i ? uop_i.rs2_tag : pick.rs2_tag;

    // ############################################################
    // ALU
    assign op_b = pick.use_imm ? pick.imm : rd_val_b_i;

    always_comb begin
        case (pick.op)
            ALU_SUB: result = rd_val_a_i - op_b;
            ALU_AND: result = rd_val_a_i & op_b;
            ALU_OR:  result = rd_val_a_i | op_b;
            ALU_XOR: result = rd_val_a_i ^ op_b;
            default: result = rd_val_a_i + op_b;
        endcase
    end

    // ############################################################
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            rdy_a_q <= '0;
            rdy_b_q <= '0;
            cdb_o   <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (valid_q[i] && wake(slot_q[i].rs1_tag, cdb_i)) begin
                    rdy_a_q[i] <= 1'b1;
                end
                if (valid_q[i] && wake(slot_q[i].rs2_tag, cdb_i)) begin
                    rdy_b_q[i] <= 1'b1;
                end
            end
            if (insert_i) begin
                for (int i = 0; i < RS_DEPTH; i++) begin
                    if (valid_q[i]) begin
                        age_q[i] <= age_q[i] + 1'b1;
                    end
                end
                valid_q[free_idx] <= 1'b1;
                age_q[free_idx]   <= '0;
                rdy_a_q[free_idx] <= rd_rdy_a_i || wake(uop_i.rs1_tag, cdb_i);
                rdy_b_q[free_idx] <= rd_rdy_b_i || wake(uop_i.rs2_tag, cdb_i);
            end else if (issue) begin
                valid_q[pick_idx] <= 1'b0;
                // Close the gap so ages stay below RS_DEPTH
                for (int i = 0; i < RS_DEPTH; i++) begin
                    if (valid_q[i] && age_q[i] > best_age) begin
                        age_q[i] <= age_q[i] - 1'b1;
                    end
                end
            end
            cdb_o.valid      <= issue;
            cdb_o.tag        <= pick.dst_tag;
            cdb_o.dest_valid <= pick.dst_valid;
            cdb_o.rob_id     <= pick.rob_id;
            cdb_o.value      <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (insert_i) begin
            slot_q[free_idx] <= uop_i;
        end
    end

endmodule

//--- logic/prf.sv
`timescale 1ns/10ps

module prf #(
    parameter int PHYS_REGS = 48
) (
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  logic                         alloc_i,
    input  backend_pkg::phys_tag_t       alloc_tag_i,
    input  backend_pkg::cdb_t            cdb_i,

    input  backend_pkg::phys_tag_t       rd_tag_a_i,
    output logic [backend_pkg::XLEN-1:0] rd_val_a_o,
    output logic                         rd_rdy_a_o,
    input  backend_pkg::phys_tag_t       rd_tag_b_i,
    output logic [backend_pkg::XLEN-1:0] rd_val_b_o,
    output logic                         rd_rdy_b_o
);
    import backend_pkg::*;

    logic [XLEN-1:0]      regs_q [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready_q;

    assign rd_val_a_o = regs_q[rd_tag_a_i];
    assign rd_rdy_a_o = ready_q[rd_tag_a_i];
    assign rd_val_b_o = regs_q[rd_tag_b_i];
    assign rd_rdy_b_o = ready_q[rd_tag_b_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_q <= '1;
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (alloc_i) begin
                ready_q[alloc_tag_i] <= 1'b0;  // Busy until its result arrives
            end
            if (cdb_i.valid && cdb_i.dest_valid) begin
                regs_q[cdb_i.tag]  <= cdb_i.value;
                ready_q[cdb_i.tag] <= 1'b1;
            end
        end
    end

endmodule

//--- logic/backend_top.sv
`timescale 1ns/10ps

module backend_top #(
    parameter int PHYS_REGS = 48,
    parameter int ROB_DEPTH = 8,
    parameter int RS_DEPTH  = 4
) (
    input  logic        clk,
    input  logic        rst_n_i,

    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    output logic        instr_ready_o,

    output logic        commit_valid_o,
    output logic [4:0]  commit_rd_o,
    output logic [31:0] commit_value_o
);
    import backend_pkg::*;

    logic [ARCH_W-1:0] rs1_arch;
    logic [ARCH_W-1:0] rs2_arch;
    phys_tag_t         rs1_tag;
    phys_tag_t         rs2_tag;
    phys_tag_t         fl_tag;
    logic              fl_ready;
    logic              fl_pop;
    logic              rat_we;
    logic              rob_ready;
    rob_id_t           rob_tail;
    logic              rob_alloc;
    rob_alloc_t        alloc_data;
    logic              rs_ready;
    logic              rs_insert;
    uop_t              uop;
    cdb_t              cdb;
    commit_t           commit;
    logic              free;
    phys_tag_t         free_tag;
    phys_tag_t         prf_tag_a;
    phys_tag_t         prf_tag_b;
    logic [XLEN-1:0]   prf_val_a;
    logic [XLEN-1:0]   prf_val_b;
    logic              prf_rdy_a;
    logic              prf_rdy_b;

    assign commit_rd_o    = commit.rd_arch;
    assign commit_value_o = commit.value;

    // ############################################################
    // Rename and dispatch
    id_stage id_stage_i (
        .instr_valid_i          (instr_valid_i),
        .instr_i                (instr_i),
        .instr_ready_o          (instr_ready_o),
        .rob_ready_i            (rob_ready),
        .fl_ready_i             (fl_ready),
        .rs_ready_i             (rs_ready),
        .rs1_o                  (rs1_arch),
        .rs2_o                  (rs2_arch),
        .rs1_tag_i              (rs1_tag),
        .rs2_tag_i              (rs2_tag),
        .new_tag_i              (fl_tag),
        .rob_id_i               (rob_tail),
        .rat_we_o               (rat_we),
        .fl_pop_o               (fl_pop),
        .rob_alloc_o            (rob_alloc),
        .alloc_data_o           (alloc_data),
        .rs_insert_o            (rs_insert),
        .uop_o                  (uop)
    );

    rat rat_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .rs1_i                  (rs1_arch),
        .rs2_i                  (rs2_arch),
        .rs1_tag_o              (rs1_tag),
        .rs2_tag_o              (rs2_tag),
        .we_i                   (rat_we),
        .rd_i                   (alloc_data.rd_arch),
        .rd_tag_i               (alloc_data.tag)
    );

    free_list #(.PHYS_REGS(PHYS_REGS)) free_list_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .pop_i                  (fl_pop),
        .tag_o                  (fl_tag),
        .ready_o                (fl_ready),
        .push_i                 (free),
        .push_tag_i             (free_tag)
    );

    // ############################################################
    // Retirement
    rob #(.ROB_DEPTH(ROB_DEPTH)) rob_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .alloc_i                (rob_alloc),
        .alloc_data_i           (alloc_data),
        .tail_id_o              (rob_tail),
        .ready_o                (rob_ready),
        .cdb_i                  (cdb),
        .commit_valid_o         (commit_valid_o),
        .commit_o               (commit)
    );

    rrf rrf_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .commit_valid_i         (commit_valid_o),
        .commit_i               (commit),
        .free_o                 (free),
        .free_tag_o             (free_tag)
    );

    // ############################################################
    // Issue, execute and register file
    int_rs #(.RS_DEPTH(RS_DEPTH), .PHYS_REGS(PHYS_REGS)) int_rs_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .insert_i               (rs_insert),
        .uop_i                  (uop),
        .ready_o                (rs_ready),
        .cdb_i                  (cdb),
        .rd_tag_a_o             (prf_tag_a),
        .rd_tag_b_o             (prf_tag_b),
        .rd_val_a_i             (prf_val_a),
        .rd_val_b_i             (prf_val_b),
        .rd_rdy_a_i             (prf_rdy_a),
        .rd_rdy_b_i             (prf_rdy_b),
        .cdb_o                  (cdb)
    );

    prf #(.PHYS_REGS(PHYS_REGS)) prf_i (
        .clk                    (clk),
        .rst_n_i                (rst_n_i),
        .alloc_i                (fl_pop),
        .alloc_tag_i            (fl_tag),
        .cdb_i                  (cdb),
        .rd_tag_a_i             (prf_tag_a),
        .rd_val_a_o             (prf_val_a),
        .rd_rdy_a_o             (prf_rdy_a),
        .rd_tag_b_i             (prf_tag_b),
        .rd_val_b_o             (prf_val_b),
        .rd_rdy_b_o             (prf_rdy_b)
    );

endmodule

//--- sim/backend_tb.sv
`timescale 1ns/10ps

module backend_tb;

    localparam int MAX_INSTR = 64;
    localparam int HALF_CLK  = 50;

    logic        clk;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        instr_ready_o;
    logic        commit_valid_o;
    logic [4:0]  commit_rd_o;
    logic [31:0] commit_value_o;

    int          test_id   [MAX_INSTR];
    logic [31:0] word      [MAX_INSTR];
    int          gap       [MAX_INSTR];
    logic [4:0]  exp_rd    [MAX_INSTR];
    logic [31:0] exp_value [MAX_INSTR];

    int     n_instr    = 0;
    int     n_tests    = 0;
    int     limit      = 0;
    int     cycles     = 0;
    int     commit_cnt = 0;
    int     check_errs = 0;
    int     load_errs  = 0;
    int     test_start = 0;  // First commit index of the running test
    int     err_mark   = 0;
    integer seed;

    backend_top backend_top_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_CLK clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // ############################################################
    // Lines starting with # in the stimulus file are skipped
    task automatic load_stimulus();
        int          fd;
        int          cnt;
        int          t;
        int          g;
        int          rd;
        logic [31:0] w;
        logic [31:0] v;
        string       line;
        fd = $fopen("sim/backend_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open sim/backend_stimulus.txt");
            load_errs++;
            return;
        end
        while (!$feof(fd) && n_instr < MAX_INSTR) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue;
            cnt = $sscanf(line, "%d %h %d %d %h", t, w, g, rd, v);
            if (cnt == 5) begin
                test_id[n_instr]   = t;
                word[n_instr]      = w;
                gap[n_instr]       = g;
                exp_rd[n_instr]    = 5'(rd);
                exp_value[n_instr] = v;
                n_instr++;
            end
        end
        $fclose(fd);
        if (n_instr == 0) begin
            $display("ERROR: stimulus file holds no instructions");
            load_errs++;
        end
    endtask

    // ############################################################
    initial begin : main
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        rst_n_i       <= 1'b0;
        seed = 32'ha0248436;
        load_stimulus();
        limit = 20 * n_instr;
        for (int i = 0; i < n_instr; i++) begin
            limit = limit + ((gap[i] < 0) ? 3 : gap[i]);  // Random gap is at most 3
            if (i == 0 || test_id[i] != test_id[i - 1]) n_tests++;
        end
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        wait (commit_cnt >= n_instr || cycles >= limit);
        if (commit_cnt < n_instr) begin
            $display("ERROR: timeout after %0d cycles, commits %0d to %0d never arrived",
                     cycles, commit_cnt, n_instr - 1);
        end else begin
            repeat (4) @(posedge clk);  // A stray commit would show up here
        end
        $display("Summary: %0d tests, %0d of %0d commits seen, %0d check errors",
                 n_tests, commit_cnt, n_instr, check_errs);
        if (load_errs == 0 && check_errs == 0 && commit_cnt == n_instr) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Holds each word until the DUT takes it
    initial begin : driver
        int g;
        @(posedge clk);
        while (!rst_n_i) @(posedge clk);
        for (int i = 0; i < n_instr; i++) begin
            g = (gap[i] < 0) ? int'($unsigned($random(seed)) % 4) : gap[i];
            if (g > 0) begin
                instr_valid_i <= 1'b0;
                repeat (g) @(posedge clk);
            end
            instr_valid_i <= 1'b1;
            instr_i       <= word[i];
            @(negedge clk);
            while (!instr_ready_o) @(negedge clk);
            @(posedge clk);  // Accepted here
        end
        instr_valid_i <= 1'b0;
    end

    // ############################################################
    // Commits are checked in program order at the falling edge
    always @(negedge clk) begin
        if (rst_n_i && commit_valid_o) begin
            if (commit_cnt >= n_instr) begin
                $display("ERROR: commit of x%0d came after the last expected instruction",
                         commit_rd_o);
                check_errs++;
            end else begin
                if (commit_rd_o !== exp_rd[commit_cnt]) begin
                    $display("CHECK FAILED commit_rd_o at commit %0d: got %h, expected %h",
                             commit_cnt, commit_rd_o, exp_rd[commit_cnt]);
                    check_errs++;
                end
                if (commit_value_o !== exp_value[commit_cnt]) begin
                    $display("CHECK FAILED commit_value_o at commit %0d: got %h, expected %h",
                             commit_cnt, commit_value_o, exp_value[commit_cnt]);
                    check_errs++;
                end
                if (commit_cnt == n_instr - 1 ||
                    test_id[commit_cnt + 1] != test_id[commit_cnt]) begin
                    $display("Test %0d finished: %0d commits checked, %0d errors",
                             test_id[commit_cnt], commit_cnt + 1 - test_start,
                             check_errs - err_mark);
                    test_start = commit_cnt + 1;
                    err_mark   = check_errs;
                end
            end
            commit_cnt++;
        end
    end

endmodule

//--- sim/backend_stimulus.txt
# test  instr     gap  rd  value
# gap is idle cycles before the instruction, -1 picks 0 to 3 at random
1  00500093   0   1  00000005
1  FFD00113   1   2  FFFFFFFD
1  12300193   2   3  00000123
1  00208233   0   4  00000002
2  00118293   0   5  00000124
2  40128333   0   6  0000011F
2  005343B3   0   7  0000003B
3  01000413   1   8  00000010
3  008404B3   0   9  00000020
3  00740413   0   8  00000017
3  00946533   3  10  00000037
4  00358593   0  11  00000003
4  00358593   0  11  00000006
4  00358593   0  11  00000009
4  00358593   0  11  0000000C
4  00358593   0  11  0000000F
4  00358593   0  11  00000012
4  00358593   0  11  00000015
4  00358593   0  11  00000018
4  00358593   0  11  0000001B
5  05508013   2   0  00000000
5  00100633   0  12  00000005
6  00A3F6B3  -1  13  00000033
6  FFF68713  -1  14  00000032
6  40E107B3  -1  15  FFFFFFCB
6  00B7C833  -1  16  FFFFFFD0
6  00C808B3  -1  17  FFFFFFD5

//--- backend_top.f
common/backend_pkg.sv
rename/rat.sv
rename/free_list.sv
rename/rrf.sv
rob/rob.sv
logic/id_stage.sv
logic/int_rs.sv
logic/prf.sv
logic/backend_top.sv
sim/backend_tb.sv

//--- Makefile
TOP = backend_tb

all: run

obj_dir/V$(TOP): backend_top.f $(wildcard common/*.sv rename/*.sv rob/*.sv logic/*.sv sim/*.sv)
	verilator --binary --timing --top-module $(TOP) -f backend_top.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f backend_top.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
